/* verilog.f */
+incdir+source
source/ddr_rd_pkg.sv
source/sync_fifo.sv
source/beat_pair_assembler.sv
source/ddr_rd_tracker.sv
source/ddr_cmd_issue.sv
source/ddr_rd_subsys.sv
dv/ddr_mem_model.sv
dv/ddr_rd_subsys_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the DDR read subsystem testbench with Verilator, run it, look for the pass line
verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f \
    --top-module ddr_rd_subsys_tb -o ddr_rd_sim || exit 1
out=$(./obj_dir/ddr_rd_sim 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "ALL CHECKS PASSED" && exit 0 || exit 1

/* dv/ddr_rd_subsys_tb.sv */
/*
 * DDR read subsystem testbench
 * runs a table of traffic scenarios against the DUT and a controller model,
 * scoreboards every accepted address and checks flow control every cycle
 */
`include "ddr_rd_macros.svh"

module ddr_rd_subsys_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import ddr_rd_pkg::*;

    typedef struct packed {
        adx_t       start;
        logic [7:0] count;
        logic [7:0] duty;
        logic       stall;
    } scenario_t;

    // start address, requests, app_rdy duty in percent, consumer stalls until full
    localparam scenario_t SCENARIOS [5] = '{
        '{27'h0000100, 8'd24,  8'd100, 1'b0},
        '{27'h1234560, 8'd48,  8'd50,  1'b0},
        '{27'h7FFFF00, 8'd72,  8'd100, 1'b1},
        '{27'h0ABCDE0, 8'd120, 8'd30,  1'b0},
        '{27'h2468ACE, 8'd80,  8'd65,  1'b1}
    };
    localparam int ROW_TIMEOUT = 8000;

    logic  clk;
    logic  resetn;
    adx_t  read_address;
    logic  read_req;
    logic  read_allowed;
    logic  reads_pending;
    logic  app_cmd_en;
    adx_t  app_cmd_adx;
    logic  app_rdy;
    logic  app_rd_data_valid;
    beat_t app_rd_data;
    logic  return_data_available;
    adx_t  return_adx;
    line_t return_data;
    logic  get_return_data;
    logic [7:0] rdy_duty;

    // accepted addresses, oldest first
    adx_t sb_q [$];
    // reads accepted and not yet popped
    int   outstanding;

    ddr_mem_model mem_model_i (
        .clk(clk), .resetn(resetn), .rdy_duty(rdy_duty),
        .app_cmd_en(app_cmd_en), .app_cmd_adx(app_cmd_adx), .app_rdy(app_rdy),
        .app_rd_data_valid(app_rd_data_valid), .app_rd_data(app_rd_data)
    );

    ddr_rd_subsys dut_i (
        .clk(clk), .resetn(resetn), .read_address(read_address), .read_req(read_req),
        .read_allowed(read_allowed), .reads_pending(reads_pending),
        .app_cmd_en(app_cmd_en), .app_cmd_adx(app_cmd_adx), .app_rdy(app_rdy),
        .app_rd_data_valid(app_rd_data_valid), .app_rd_data(app_rd_data),
        .return_data_available(return_data_available), .return_adx(return_adx),
        .return_data(return_data), .get_return_data(get_return_data)
    );

    always #20 clk = ~clk;

    // line the controller returns for an address, second beat on top
    function automatic line_t line_for(input adx_t a);
        beat_t lo;
        beat_t hi;
        lo = beat_t'(a) ^ 64'hA5A5_0000_0000_0000;
        hi = beat_t'(a) ^ 64'h0000_0000_5A5A_FFFF;
        return {hi, lo};
    endfunction

    task automatic stop_with_failure();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    // read_allowed and reads_pending follow the outstanding count
    task automatic check_flow_flags();
        logic exp_allowed;
        exp_allowed = outstanding < `DDR_RD_DEPTH;
        assert (read_allowed === exp_allowed) else begin
            $display("MISMATCH at %0t ns: read_allowed %0b, expected %0b with %0d outstanding",
                     $time, read_allowed, exp_allowed, outstanding);
            stop_with_failure();
        end
        assert (reads_pending === (outstanding != 0)) else begin
            $display("MISMATCH at %0t ns: reads_pending %0b with %0d outstanding",
                     $time, reads_pending, outstanding);
            stop_with_failure();
        end
    endtask

    // head entry must be the oldest accepted address and its line
    task automatic check_head();
        assert (sb_q.size() != 0) else begin
            $display("return entry showed up with no accepted request left");
            stop_with_failure();
        end
        assert (return_adx === sb_q[0]) else begin
            $display("MISMATCH at %0t ns: return_adx %h, expected %h", $time, return_adx, sb_q[0]);
            stop_with_failure();
        end
        assert (return_data === line_for(sb_q[0])) else begin
            $display("MISMATCH at %0t ns: return_data %h, expected %h",
                     $time, return_data, line_for(sb_q[0]));
            stop_with_failure();
        end
    endtask

    task automatic run_scenario(input scenario_t sc, input int idx);
        int   accepted;
        int   rejected;
        int   cycles;
        logic stalled;
        accepted = 0;
        rejected = 0;
        cycles   = 0;
        rdy_duty <= sc.duty;
        while (!(accepted == int'(sc.count) && outstanding == 0)) begin
            if (cycles == ROW_TIMEOUT) begin
                $display("timeout: scenario %0d did not drain within %0d cycles", idx, cycles);
                stop_with_failure();
            end
            cycles++;
            @(posedge clk);
            check_flow_flags();
            // a request counts only when read_allowed was high at this edge
            if (read_req) begin
                if (read_allowed) begin
                    sb_q.push_back(read_address);
                    accepted++;
                    outstanding++;
                end else begin
                    rejected++;
                end
            end
            if (get_return_data) begin
                outstanding--;
            end
            // stalled consumer waits for a full buffer and a few refused requests
            stalled = sc.stall && !(accepted >= `DDR_RD_DEPTH && rejected >= 8);
            // pop every other cycle so the checked head is the one taken
            if (!stalled && return_data_available && !get_return_data) begin
                check_head();
                void'(sb_q.pop_front());
                get_return_data <= 1'b1;
            end else begin
                get_return_data <= 1'b0;
            end
            if (accepted < int'(sc.count)) begin
                read_req     <= 1'b1;
                read_address <= sc.start + 27'(4 * accepted);
            end else begin
                read_req <= 1'b0;
            end
        end
        // last pop was taken at this edge, the emptied buffer shows one cycle on
        @(posedge clk);
        assert (reads_pending === 1'b0 && return_data_available === 1'b0) else begin
            $display("MISMATCH at %0t ns: drained but pending %0b, available %0b",
                     $time, reads_pending, return_data_available);
            stop_with_failure();
        end
    endtask

    initial begin
        clk             = 1'b0;
        resetn          = 1'b0;
        read_address    = '0;
        read_req        = 1'b0;
        get_return_data = 1'b0;
        rdy_duty        = 8'd100;
        outstanding     = 0;
        repeat (16) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);
        // idle flags straight out of reset
        assert (read_allowed === 1'b1 && reads_pending === 1'b0
                && return_data_available === 1'b0 && app_cmd_en === 1'b0) else begin
            $display("MISMATCH at %0t ns: after reset allowed %0b, pending %0b, available %0b",
                     $time, read_allowed, reads_pending, return_data_available);
            $display("MISMATCH at %0t ns: after reset app_cmd_en %0b", $time, app_cmd_en);
            stop_with_failure();
        end
        for (int s = 0; s < 5; s++) begin
            run_scenario(SCENARIOS[s], s);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* dv/ddr_mem_model.sv */
/*
 * DDR controller model
 * takes read commands while app_rdy is high, app_rdy follows a seeded
 * xorshift stream at a given duty in percent
 * returns two beats per command, in command order, after a fixed delay
 */
module ddr_mem_model (
    input  logic              clk,
    input  logic              resetn,
    input  logic [7:0]        rdy_duty,
    input  logic              app_cmd_en,
    input  ddr_rd_pkg::adx_t  app_cmd_adx,
    output logic              app_rdy,
    output logic              app_rd_data_valid,
    output ddr_rd_pkg::beat_t app_rd_data
);
    timeunit 1ns;
    timeprecision 1ps;

    import ddr_rd_pkg::*;

    localparam logic [31:0] RDY_SEED  = 32'h7056;
    // cycles from command acceptance to first beat
    localparam int          RET_DELAY = 5;

    logic [31:0] rnd_q;
    logic        second_q;
    adx_t        cmd_q [$];
    int          due_q [$];
    int          cycle;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    always @(posedge clk) begin
        if (!resetn) begin
            rnd_q             <= RDY_SEED;
            app_rdy           <= 1'b0;
            app_rd_data_valid <= 1'b0;
            app_rd_data       <= '0;
            second_q          <= 1'b0;
            cycle = 0;
            cmd_q.delete();
            due_q.delete();
        end else begin
            cycle = cycle + 1;
            rnd_q   <= xorshift32(rnd_q);
            app_rdy <= (rnd_q % 32'd100) < 32'(rdy_duty);
            if (second_q) begin
                // upper half closes the pair, command retires
                app_rd_data_valid <= 1'b1;
                app_rd_data       <= beat_t'(cmd_q[0]) ^ 64'h0000_0000_5A5A_FFFF;
                second_q          <= 1'b0;
                void'(cmd_q.pop_front());
                void'(due_q.pop_front());
            end else if (cmd_q.size() != 0 && due_q[0] <= cycle) begin
                // lower half goes first
                app_rd_data_valid <= 1'b1;
                app_rd_data       <= beat_t'(cmd_q[0]) ^ 64'hA5A5_0000_0000_0000;
                second_q          <= 1'b1;
            end else begin
                app_rd_data_valid <= 1'b0;
            end
            // command taken on en and rdy together
            if (app_cmd_en && app_rdy) begin
                cmd_q.push_back(app_cmd_adx);
                due_q.push_back(cycle + RET_DELAY);
            end
        end
    end

endmodule

/* source/ddr_rd_subsys.sv */
/*
 * DDR read subsystem top
 * read tracker plus command issuer between a traffic source,
 * the memory controller and a consumer of tagged read lines
 */
module ddr_rd_subsys (
    input  logic              clk,
    input  logic              resetn,
    // traffic source
    input  ddr_rd_pkg::adx_t  read_address,
    input  logic              read_req,
    output logic              read_allowed,
    output logic              reads_pending,
    // controller command side
    output logic              app_cmd_en,
    output ddr_rd_pkg::adx_t  app_cmd_adx,
    input  logic              app_rdy,
    // controller return side
    input  logic              app_rd_data_valid,
    input  ddr_rd_pkg::beat_t app_rd_data,
    // consumer
    output logic              return_data_available,
    output ddr_rd_pkg::adx_t  return_adx,
    output ddr_rd_pkg::line_t return_data,
    input  logic              get_return_data
);

    import ddr_rd_pkg::*;

    // tracker to issuer
    logic has_rd_req;
    adx_t issue_adx;
    logic issue_pop;

    ddr_rd_tracker u_tracker (
        .clk                   (clk),
        .resetn                (resetn),
        .read_address          (read_address),
        .read_req              (read_req),
        .read_allowed          (read_allowed),
        .reads_pending         (reads_pending),
        .has_rd_req            (has_rd_req),
        .issue_adx             (issue_adx),
        .issue_pop             (issue_pop),
        .app_rd_data_valid     (app_rd_data_valid),
        .app_rd_data           (app_rd_data),
        .return_data           (return_data),
        .return_adx            (return_adx),
        .return_data_available (return_data_available),
        .get_return_data       (get_return_data)
    );

    ddr_cmd_issue u_issue (
        .clk         (clk),
        .resetn      (resetn),
        .has_rd_req  (has_rd_req),
        .issue_adx   (issue_adx),
        .issue_pop   (issue_pop),
        .app_cmd_en  (app_cmd_en),
        .app_cmd_adx (app_cmd_adx),
        .app_rdy     (app_rdy)
    );

endmodule

/* source/ddr_cmd_issue.sv */
/*
 * DDR command issuer
 * presents the head of the issue queue to the controller as a command strobe
 * and pops the queue in each cycle the controller takes it
 */
module ddr_cmd_issue (
    input  logic             clk,
    input  logic             resetn,
    input  logic             has_rd_req,
    input  ddr_rd_pkg::adx_t issue_adx,
    output logic             issue_pop,
    output logic             app_cmd_en,
    output ddr_rd_pkg::adx_t app_cmd_adx,
    input  logic             app_rdy
);

    localparam int ISSUED_W = 16;

    // running count of commands the controller has taken
    logic [ISSUED_W-1:0] issued_q;

    // zero-cycle path, command follows the queue head directly
    assign app_cmd_en  = has_rd_req;
    assign app_cmd_adx = issue_adx;
    // taken only when the controller is ready
    assign issue_pop   = app_cmd_en && app_rdy;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            issued_q <= '0;
        end else if (issue_pop) begin
            issued_q <= issued_q + ISSUED_W'(1);
        end
    end

    // nothing taken since last cycle means the same command is still on offer
    a_hold_while_stalled: assert property (@(posedge clk) disable iff (!resetn)
        ($past(app_cmd_en) && (issued_q == $past(issued_q)))
        |-> (app_cmd_en && $stable(app_cmd_adx)));

endmodule

/* source/ddr_rd_tracker.sv */
/*
 * DDR read tracker
 * queues each accepted read twice, once for issue and once as a pending tag,
 * joins returned beats into lines tagged with the oldest pending address
 * and holds them in a return buffer for the consumer
 * read_allowed drops once a full buffer's worth of reads is outstanding
 */
`include "ddr_rd_macros.svh"

module ddr_rd_tracker (
    input  logic              clk,
    input  logic              resetn,
    input  ddr_rd_pkg::adx_t  read_address,
    input  logic              read_req,
    output logic              read_allowed,
    output logic              reads_pending,
    output logic              has_rd_req,
    output ddr_rd_pkg::adx_t  issue_adx,
    input  logic              issue_pop,
    input  logic              app_rd_data_valid,
    input  ddr_rd_pkg::beat_t app_rd_data,
    output ddr_rd_pkg::line_t return_data,
    output ddr_rd_pkg::adx_t  return_adx,
    output logic              return_data_available,
    input  logic              get_return_data
);

    import ddr_rd_pkg::*;

    logic                  req_ok;
    logic                  issue_empty;
    logic [`DDR_CNT_W-1:0] issue_count;
    adx_t                  pend_head;
    logic                  pend_empty;
    logic [`DDR_CNT_W-1:0] pend_count;
    logic                  pend_pop;
    line_t                 line;
    logic                  line_wr;
    adx_t                  line_adx_q;
    rd_entry_t             entry_in;
    rd_entry_t             entry_out;
    logic                  buf_empty;
    logic [`DDR_CNT_W-1:0] buf_count;
    logic [`DDR_CNT_W:0]   outstanding;

    // requests while throttled are dropped
    assign req_ok = read_req && read_allowed;

    // addresses waiting to go out to the controller
    sync_fifo #(.WIDTH($bits(adx_t))) u_issue_q (
        .clk(clk), .resetn(resetn), .wr_en(req_ok), .rd_en(issue_pop),
        .din(read_address), .dout(issue_adx), .empty(issue_empty), .count(issue_count)
    );

    // addresses waiting for their data, in issue order
    sync_fifo #(.WIDTH($bits(adx_t))) u_pend_q (
        .clk(clk), .resetn(resetn), .wr_en(req_ok), .rd_en(pend_pop),
        .din(read_address), .dout(pend_head), .empty(pend_empty), .count(pend_count)
    );

    beat_pair_assembler u_asm (
        .clk(clk), .resetn(resetn), .beat_valid(app_rd_data_valid), .beat(app_rd_data),
        .pending_empty(pend_empty), .line(line), .pend_pop(pend_pop), .line_wr(line_wr)
    );

    // head moves on at the pop, so keep the tag for next cycle's write
    always_ff @(posedge clk) begin
        if (pend_pop) begin
            line_adx_q <= pend_head;
        end
    end

    assign entry_in.adx  = line_adx_q;
    assign entry_in.line = line;

    // tagged lines for the consumer
    sync_fifo #(.WIDTH($bits(rd_entry_t))) u_ret_buf (
        .clk(clk), .resetn(resetn), .wr_en(line_wr), .rd_en(get_return_data),
        .din(entry_in), .dout(entry_out), .empty(buf_empty), .count(buf_count)
    );

    assign has_rd_req            = !issue_empty;
    assign return_adx            = entry_out.adx;
    assign return_data           = entry_out.line;
    assign return_data_available = !buf_empty;

    // reads in flight: pending, buffered, plus a line on its way into the buffer
    assign outstanding = {1'b0, pend_count} + {1'b0, buf_count}
                       + (`DDR_CNT_W+1)'(line_wr);
    assign read_allowed  = outstanding < (`DDR_CNT_W+1)'(`DDR_RD_DEPTH);
    assign reads_pending = outstanding != '0;

    // every issued address is still pending until its data comes back
    a_issue_within_pending: assert property (@(posedge clk) disable iff (!resetn)
        issue_count <= pend_count);

    a_no_pop_when_empty: assert property (@(posedge clk) disable iff (!resetn)
        get_return_data |-> return_data_available);

endmodule

/* source/beat_pair_assembler.sv */
/*
 * Beat pair assembler
 * joins the two 64-bit beats of one read return into a 128-bit line
 * pops the pending address on the second beat, writes the line a cycle later
 */
module beat_pair_assembler (
    input  logic               clk,
    input  logic               resetn,
    input  logic               beat_valid,
    input  ddr_rd_pkg::beat_t  beat,
    input  logic               pending_empty,
    output ddr_rd_pkg::line_t  line,
    output logic               pend_pop,
    output logic               line_wr
);

    import ddr_rd_pkg::*;

    localparam logic ST_IDLE       = 1'b0;
    localparam logic ST_HAVE_FIRST = 1'b1;

    logic  state_q;
    logic  start;
    logic  line_wr_q;
    beat_t lo_q;
    beat_t hi_q;

    // a pair only opens when some address is waiting for data
    assign start    = (state_q == ST_IDLE) && beat_valid && !pending_empty;
    // second beat closes the pair
    assign pend_pop = (state_q == ST_HAVE_FIRST) && beat_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q   <= ST_IDLE;
            line_wr_q <= 1'b0;
        end else begin
            line_wr_q <= pend_pop;
            if (start) begin
                state_q <= ST_HAVE_FIRST;
            end else if (pend_pop) begin
                state_q <= ST_IDLE;
            end
        end
    end

    // beat capture
    always_ff @(posedge clk) begin
        if (start) begin
            lo_q <= beat;
        end
        if (pend_pop) begin
            hi_q <= beat;
        end
    end

    // first beat is the lower half
    assign line    = {hi_q, lo_q};
    assign line_wr = line_wr_q;

    // controller must never return data that nobody asked for
    a_beat_has_owner: assert property (@(posedge clk) disable iff (!resetn)
        beat_valid |-> !pending_empty);

endmodule

/* source/sync_fifo.sv */
/*
 * Synchronous show-ahead FIFO
 * register array with read/write pointers and an occupancy count
 * head word is visible on dout with no read latency
 */
`include "ddr_rd_macros.svh"

module sync_fifo #(
    parameter int WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  wr_en,
    input  logic                  rd_en,
    input  logic [WIDTH-1:0]      din,
    output logic [WIDTH-1:0]      dout,
    output logic                  empty,
    output logic [`DDR_CNT_W-1:0] count
);

    localparam int DEPTH = `DDR_RD_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    // storage array
    logic [WIDTH-1:0] mem [DEPTH];

    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [`DDR_CNT_W-1:0] count_q;
    logic                  full;

    // pointers and count
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
        end else begin
            // depth is a power of two so the pointers just wrap
            if (wr_en) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + `DDR_CNT_W'(1);
                2'b01:   count_q <= count_q - `DDR_CNT_W'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    // data write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    // show-ahead head word
    assign dout  = mem[rd_ptr];
    assign empty = (count_q == '0);
    assign full  = (count_q == `DDR_CNT_W'(DEPTH));
    assign count = count_q;

    // callers must respect the flags
    a_no_overflow: assert property (@(posedge clk) disable iff (!resetn)
        wr_en |-> !full);

    a_no_underflow: assert property (@(posedge clk) disable iff (!resetn)
        rd_en |-> !empty);

endmodule

/* source/ddr_rd_pkg.sv */
/*
 * DDR read path types
 * address, beat, joined line and the tagged entry kept in the return buffer
 */
`include "ddr_rd_macros.svh"

package ddr_rd_pkg;

    // read address as sent to the controller
    typedef logic [`DDR_ADX_W-1:0] adx_t;

    // single data beat from the controller
    typedef logic [`DDR_BEAT_W-1:0] beat_t;

    // joined line, second beat sits in the upper half
    typedef logic [2*`DDR_BEAT_W-1:0] line_t;

    // return buffer word, address in the top bits
    typedef struct packed {
        adx_t  adx;
        line_t line;
    } rd_entry_t;

endpackage

/* source/ddr_rd_macros.svh */
/*
 * DDR read path parameters
 * widths and depths shared by the read tracker, its FIFOs and the top level
 */
`ifndef DDR_RD_MACROS_SVH
`define DDR_RD_MACROS_SVH

// controller address width
`define DDR_ADX_W 27
// one returned beat, a line is two of these
`define DDR_BEAT_W 64
// depth of every queue, also the outstanding read limit
`define DDR_RD_DEPTH 64
// occupancy counts, wide enough to hold a full 64
`define DDR_CNT_W 7

`endif
